// ==== rv_decode_cases.txt ====
// instr pc op rs1 rs2 rd imm shamt err, all hex, one case per line
// op numbers follow dec_op_e order with op_none as 0
002081b3 00001000 0a 01 02 03 00000000 00 0
407302b3 00001004 0b 06 07 05 00000000 00 0
40c5d533 00001008 11 0b 0c 0a 00000000 00 0
003130b3 0000100c 0e 02 03 01 00000000 00 0
ffb10093 00001010 01 02 00 01 fffffffb 00 0
7ff2c213 00001014 05 05 00 04 000007ff 00 0
01f39313 00001018 02 07 00 06 00000000 1f 0
4034d413 0000101c 07 09 00 08 00000000 03 0
0111d113 00001020 06 03 00 02 00000000 11 0
0f057493 00001024 09 0a 00 09 000000f0 00 0
fe208ce3 00001028 16 01 02 00 fffffff8 00 0
0062f863 0000102c 1b 05 06 00 00000010 00 0
001000ef 00001030 14 00 00 01 00000800 00 0
ffdff06f 00001034 14 00 00 00 fffffffc 00 0
00c280e7 00001038 15 05 00 01 0000000c 00 0
800003b7 0000103c 1c 00 00 07 80000000 00 0
12345197 00001040 1d 00 00 03 12345000 00 0
ffc12203 00001044 20 02 00 04 fffffffc 00 0
06434283 00001048 21 06 00 05 00000064 00 0
0084aa23 0000104c 25 09 08 00 00000014 00 0
fe110fa3 00001050 23 02 01 00 ffffffff 00 0
1234507f 00001054 26 00 00 00 00000000 00 1
fe20ace3 00001058 26 00 00 00 00000000 00 1
ffc17203 0000105c 26 00 00 00 00000000 00 1
0084ca23 00001060 26 00 00 00 00000000 00 1
022081b3 00001064 26 00 00 00 00000000 00 1

// ==== rv_decode.f ====
rv_decode_pkg.sv
rv_op_classify.sv
rv_imm_gen.sv
rv_decode_reg.sv
rv_decode_top.sv
tb_rv_decode_chk.sv
tb_rv_decode_mon.sv
tb_rv_decode.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vtb_rv_decode: rv_decode.f $(shell cat rv_decode.f)
	verilator --binary --assert --top-module tb_rv_decode -f rv_decode.f

run: obj_dir/Vtb_rv_decode rv_decode_cases.txt
	./obj_dir/Vtb_rv_decode +verilator+error+limit+100 | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_rv_decode.sv ====
module tb_rv_decode;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PC_W       = 32;
    localparam int N_CASES    = 26;
    localparam int N_COLS     = 9;
    localparam int MAX_CYCLES = 8 + 3 * N_CASES + 20;

    logic                              clk;
    logic                              rst_;
    logic                              decode_start;
    logic [rv_decode_pkg::INSTR_W-1:0] instr;
    logic [PC_W-1:0]                   pc_in;
    logic [PC_W-1:0]                   pc_next;

    logic                              exe_start;
    logic                              decode_error;
    rv_decode_pkg::dec_result_t        result;
    logic [PC_W-1:0]                   pc_out;
    logic [PC_W-1:0]                   pc_next_out;

    // Expected outcome of the case on the inputs
    rv_decode_pkg::dec_result_t        exp_result;
    logic                              exp_error;

    logic [31:0] case_mem [0:N_CASES*N_COLS-1];
    int unsigned lcg_state   = 70;
    int          cycle_count = 0;
    int          value_errors;
    int          other_errors;
    int          pending;

    rv_decode_top #(
        .PC_W (PC_W)
    ) dut (
        .clk          (clk),
        .rst_         (rst_),
        .decode_start (decode_start),
        .instr        (instr),
        .pc_in        (pc_in),
        .pc_next      (pc_next),
        .exe_start    (exe_start),
        .decode_error (decode_error),
        .result       (result),
        .pc_out       (pc_out),
        .pc_next_out  (pc_next_out)
    );

    tb_rv_decode_mon #(
        .PC_W (PC_W)
    ) u_mon (
        .clk          (clk),
        .rst_         (rst_),
        .decode_start (decode_start),
        .pc_in        (pc_in),
        .pc_next      (pc_next),
        .exp_result   (exp_result),
        .exp_error    (exp_error),
        .exe_start    (exe_start),
        .decode_error (decode_error),
        .result       (result),
        .pc_out       (pc_out),
        .pc_next_out  (pc_next_out),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    ////////////////////
    // Timeout
    ////////////////////
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Puts case idx on the inputs, with its expected result
    task automatic apply_case(input int idx);
        int base;
        base = idx * N_COLS;
        decode_start     = 1'b1;
        instr            = case_mem[base];
        pc_in            = case_mem[base+1];
        pc_next          = case_mem[base+1] + 32'd4;
        exp_result.op    = rv_decode_pkg::dec_op_e'(case_mem[base+2][5:0]);
        exp_result.rs1   = case_mem[base+3][4:0];
        exp_result.rs2   = case_mem[base+4][4:0];
        exp_result.rd    = case_mem[base+5][4:0];
        exp_result.imm   = case_mem[base+6];
        exp_result.shamt = case_mem[base+7][4:0];
        exp_error        = case_mem[base+8][0];
    endtask

    task automatic go_idle();
        decode_start = 1'b0;
        instr        = '0;
        pc_in        = '0;
        pc_next      = '0;
        exp_result   = '0;
        exp_error    = 1'b0;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int unsigned idle;
        int          leftover;
        int          assert_errors;
        int          total;
        rst_ = 1'b0;
        go_idle();
        $readmemh("rv_decode_cases.txt", case_mem);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_ = 1'b1;
        // Quiet cycles right after reset
        repeat (2) @(negedge clk);
        for (int i = 0; i < N_CASES; i++) begin
            apply_case(i);
            idle = next_random() % 3;
            repeat (idle) begin
                @(negedge clk);
                go_idle();
            end
            @(negedge clk);
        end
        go_idle();
        repeat (3) @(negedge clk);

        leftover = pending;
        if (leftover != 0)
            $display("Run ended with %0d decode results that never reached the outputs",
                     leftover);
        assert_errors = dut.u_decode_reg.u_chk.fail_count;
        total = value_errors + other_errors + leftover + assert_errors;
        $display("Errors: %0d value, %0d unexpected, %0d missing, %0d assertion",
                 value_errors, other_errors, leftover, assert_errors);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tb_rv_decode_mon.sv ====
module tb_rv_decode_mon #(
    parameter int PC_W = 32
) (
    input  logic                       clk,
    input  logic                       rst_,
    input  logic                       decode_start,
    input  logic [PC_W-1:0]            pc_in,
    input  logic [PC_W-1:0]            pc_next,
    input  rv_decode_pkg::dec_result_t exp_result,
    input  logic                       exp_error,
    input  logic                       exe_start,
    input  logic                       decode_error,
    input  rv_decode_pkg::dec_result_t result,
    input  logic [PC_W-1:0]            pc_out,
    input  logic [PC_W-1:0]            pc_next_out,
    output int                         value_errors,
    output int                         other_errors,
    output int                         pending
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic                       valid;
        logic                       error;
        rv_decode_pkg::dec_result_t res;
        logic [PC_W-1:0]            pc;
        logic [PC_W-1:0]            pc_next;
    } expect_t;

    expect_t exp_q[$];
    expect_t due;
    expect_t fresh;
    int      n_value   = 0;
    int      n_other   = 0;
    int      n_pending = 0;

    assign value_errors = n_value;
    assign other_errors = n_other;
    assign pending      = n_pending;

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, want);
            n_value++;
        end
    endtask

    // A zero expectation stands for a cleared stage
    task automatic check_outputs(input expect_t want);
        check_field("exe_start", 32'(exe_start), 32'(want.valid && !want.error));
        check_field("decode_error", 32'(decode_error), 32'(want.valid && want.error));
        check_field("op", 32'(result.op), 32'(want.res.op));
        check_field("rs1", 32'(result.rs1), 32'(want.res.rs1));
        check_field("rs2", 32'(result.rs2), 32'(want.res.rs2));
        check_field("rd", 32'(result.rd), 32'(want.res.rd));
        check_field("imm", 32'(result.imm), 32'(want.res.imm));
        check_field("shamt", 32'(result.shamt), 32'(want.res.shamt));
        check_field("pc_out", 32'(pc_out), 32'(want.pc));
        check_field("pc_next_out", 32'(pc_next_out), 32'(want.pc_next));
    endtask

    ////////////////////
    // Compare each edge
    ////////////////////
    always @(posedge clk) begin
        if (rst_) begin
            if (exp_q.size() > 0) begin
                due = exp_q.pop_front();
                check_outputs(due);
            end else if (exe_start || decode_error) begin
                $display("Unexpected strobe at %0d ns with no decode request before it",
                         $time);
                n_other++;
            end else begin
                check_outputs('0);
            end
            if (decode_start) begin
                fresh.valid   = 1'b1;
                fresh.error   = exp_error;
                fresh.res     = exp_result;
                fresh.pc      = pc_in;
                fresh.pc_next = pc_next;
                exp_q.push_back(fresh);
            end
            n_pending = exp_q.size();
        end
    end

endmodule

// ==== tb_rv_decode_chk.sv ====
module tb_rv_decode_chk (
    input logic                       clk,
    input logic                       rst_,
    input logic                       decode_start,
    input logic                       exe_start,
    input logic                       decode_error,
    input rv_decode_pkg::dec_result_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_)
        !(exe_start && decode_error))
    else begin
        $error("exe_start and decode_error are high together");
        fail_count++;
    end

    // No strobe means a cleared stage on the next edge
    a_cleared: assert property (@(posedge clk) disable iff (!rst_)
        !decode_start |=> (!exe_start && !decode_error))
    else begin
        $error("strobe raised in the cycle after an edge without decode_start");
        fail_count++;
    end

    a_op_none: assert property (@(posedge clk) disable iff (!rst_)
        !(exe_start || decode_error) |-> (result.op == rv_decode_pkg::op_none))
    else begin
        $error("op is not op_none while both strobes are low");
        fail_count++;
    end

endmodule

bind rv_decode_reg tb_rv_decode_chk u_chk (
    .clk          (clk),
    .rst_         (rst_),
    .decode_start (decode_start),
    .exe_start    (exe_start),
    .decode_error (decode_error),
    .result       (result)
);

// ==== rv_decode_top.sv ====
module rv_decode_top #(
    parameter int PC_W = 32
) (
    input  logic                              clk,
    input  logic                              rst_,
    input  logic                              decode_start,
    input  logic [rv_decode_pkg::INSTR_W-1:0] instr,
    input  logic [PC_W-1:0]                   pc_in,
    input  logic [PC_W-1:0]                   pc_next,
    output logic                              exe_start,
    output logic                              decode_error,
    output rv_decode_pkg::dec_result_t        result,
    output logic [PC_W-1:0]                   pc_out,
    output logic [PC_W-1:0]                   pc_next_out
);

    rv_decode_pkg::dec_result_t        cls;
    logic [rv_decode_pkg::XLEN-1:0]    imm;
    logic [rv_decode_pkg::SHAMT_W-1:0] shamt;

    rv_op_classify u_classify (
        .instr (instr),
        .cls   (cls)
    );

    // Immediate format follows the classified operation
    rv_imm_gen u_imm_gen (
        .instr (instr),
        .op    (cls.op),
        .imm   (imm),
        .shamt (shamt)
    );

    rv_decode_reg #(
        .PC_W (PC_W)
    ) u_decode_reg (
        .clk          (clk),
        .rst_         (rst_),
        .decode_start (decode_start),
        .cls          (cls),
        .imm          (imm),
        .shamt        (shamt),
        .pc_in        (pc_in),
        .pc_next      (pc_next),
        .result       (result),
        .exe_start    (exe_start),
        .decode_error (decode_error),
        .pc_out       (pc_out),
        .pc_next_out  (pc_next_out)
    );

endmodule

// ==== rv_decode_reg.sv ====
module rv_decode_reg #(
    parameter int PC_W = 32
) (
    input  logic                              clk,
    input  logic                              rst_,
    input  logic                              decode_start,
    input  rv_decode_pkg::dec_result_t        cls,
    input  logic [rv_decode_pkg::XLEN-1:0]    imm,
    input  logic [rv_decode_pkg::SHAMT_W-1:0] shamt,
    input  logic [PC_W-1:0]                   pc_in,
    input  logic [PC_W-1:0]                   pc_next,
    output rv_decode_pkg::dec_result_t        result,
    output logic                              exe_start,
    output logic                              decode_error,
    output logic [PC_W-1:0]                   pc_out,
    output logic [PC_W-1:0]                   pc_next_out
);

    rv_decode_pkg::dec_result_t merged;
    logic                       illegal;

    // Classifier fields plus the immediate generator's fields
    always_comb begin
        merged       = cls;
        merged.imm   = imm;
        merged.shamt = shamt;
    end

    assign illegal = (cls.op == rv_decode_pkg::op_illegal);

    ////////////////////
    // Output stage
    ////////////////////
    // An all-zero result reads as op_none
    always_ff @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            result       <= '0;
            exe_start    <= 1'b0;
            decode_error <= 1'b0;
            pc_out       <= '0;
            pc_next_out  <= '0;
        end else if (decode_start) begin
            result       <= merged;
            exe_start    <= !illegal;
            decode_error <= illegal;
            pc_out       <= pc_in;
            pc_next_out  <= pc_next;
        end else begin
            result       <= '0;
            exe_start    <= 1'b0;
            decode_error <= 1'b0;
            pc_out       <= '0;
            pc_next_out  <= '0;
        end
    end

endmodule

// ==== rv_imm_gen.sv ====
module rv_imm_gen (
    input  logic [rv_decode_pkg::INSTR_W-1:0] instr,
    input  rv_decode_pkg::dec_op_e            op,
    output logic [rv_decode_pkg::XLEN-1:0]    imm,
    output logic [rv_decode_pkg::SHAMT_W-1:0] shamt
);

    localparam int XLEN = rv_decode_pkg::XLEN;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic            is_shift_imm;

    ////////////////////
    // Format immediates
    ////////////////////
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    // Branch and jump offsets are halfword aligned
    assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                    1'b0};
    assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'h000};

    always_comb begin
        case (op)
            rv_decode_pkg::dec_addi, rv_decode_pkg::dec_slti, rv_decode_pkg::dec_sltiu,
            rv_decode_pkg::dec_xori, rv_decode_pkg::dec_ori, rv_decode_pkg::dec_andi,
            rv_decode_pkg::dec_jalr, rv_decode_pkg::dec_lb, rv_decode_pkg::dec_lh,
            rv_decode_pkg::dec_lw, rv_decode_pkg::dec_lbu, rv_decode_pkg::dec_lhu:
                imm = imm_i;
            rv_decode_pkg::dec_sb, rv_decode_pkg::dec_sh, rv_decode_pkg::dec_sw:
                imm = imm_s;
            rv_decode_pkg::dec_beq, rv_decode_pkg::dec_bne, rv_decode_pkg::dec_blt,
            rv_decode_pkg::dec_bge, rv_decode_pkg::dec_bltu, rv_decode_pkg::dec_bgeu:
                imm = imm_b;
            rv_decode_pkg::dec_jal:
                imm = imm_j;
            rv_decode_pkg::dec_lui, rv_decode_pkg::dec_auipc:
                imm = imm_u;
            // Shifts, register class and illegal
            default:
                imm = '0;
        endcase
    end

    assign is_shift_imm = (op == rv_decode_pkg::dec_slli) || (op == rv_decode_pkg::dec_srli) ||
                          (op == rv_decode_pkg::dec_srai);

    assign shamt = is_shift_imm ? instr[24:20] : '0;

endmodule

// ==== rv_op_classify.sv ====
module rv_op_classify (
    input  logic [rv_decode_pkg::INSTR_W-1:0] instr,
    output rv_decode_pkg::dec_result_t        cls
);

    rv_decode_pkg::opcode_e opcode;
    rv_decode_pkg::dec_op_e op;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   f7_zero;
    logic                   f7_alt;
    logic                   use_rs1;
    logic                   use_rs2;
    logic                   use_rd;
    logic                   legal;

    assign opcode  = rv_decode_pkg::opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    // Only bit 30 may be set, and only where it selects sub/sra
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    ////////////////////
    // Operation select
    ////////////////////
    always_comb begin
        op      = rv_decode_pkg::op_illegal;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (opcode)
            rv_decode_pkg::op_lui: begin
                op     = rv_decode_pkg::dec_lui;
                use_rd = 1'b1;
            end
            rv_decode_pkg::op_auipc: begin
                op     = rv_decode_pkg::dec_auipc;
                use_rd = 1'b1;
            end
            rv_decode_pkg::op_jal: begin
                op     = rv_decode_pkg::dec_jal;
                use_rd = 1'b1;
            end
            rv_decode_pkg::op_jalr: begin
                op      = rv_decode_pkg::dec_jalr;
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            rv_decode_pkg::op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'd0:    op = rv_decode_pkg::dec_beq;
                    3'd1:    op = rv_decode_pkg::dec_bne;
                    3'd4:    op = rv_decode_pkg::dec_blt;
                    3'd5:    op = rv_decode_pkg::dec_bge;
                    3'd6:    op = rv_decode_pkg::dec_bltu;
                    3'd7:    op = rv_decode_pkg::dec_bgeu;
                    default: op = rv_decode_pkg::op_illegal;
                endcase
            end
            rv_decode_pkg::op_load: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                case (funct3)
                    3'd0:    op = rv_decode_pkg::dec_lb;
                    3'd1:    op = rv_decode_pkg::dec_lh;
                    3'd2:    op = rv_decode_pkg::dec_lw;
                    3'd4:    op = rv_decode_pkg::dec_lbu;
                    3'd5:    op = rv_decode_pkg::dec_lhu;
                    default: op = rv_decode_pkg::op_illegal;
                endcase
            end
            rv_decode_pkg::op_store: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'd0:    op = rv_decode_pkg::dec_sb;
                    3'd1:    op = rv_decode_pkg::dec_sh;
                    3'd2:    op = rv_decode_pkg::dec_sw;
                    default: op = rv_decode_pkg::op_illegal;
                endcase
            end
            rv_decode_pkg::op_imm: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                case (funct3)
                    3'd0: op = rv_decode_pkg::dec_addi;
                    3'd1: op = f7_zero ? rv_decode_pkg::dec_slli : rv_decode_pkg::op_illegal;
                    3'd2: op = rv_decode_pkg::dec_slti;
                    3'd3: op = rv_decode_pkg::dec_sltiu;
                    3'd4: op = rv_decode_pkg::dec_xori;
                    3'd5: begin
                        if (f7_zero)
                            op = rv_decode_pkg::dec_srli;
                        else if (f7_alt)
                            op = rv_decode_pkg::dec_srai;
                    end
                    3'd6: op = rv_decode_pkg::dec_ori;
                    3'd7: op = rv_decode_pkg::dec_andi;
                endcase
            end
            rv_decode_pkg::op_reg: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
                case (funct3)
                    3'd0: begin
                        if (f7_zero)
                            op = rv_decode_pkg::dec_add;
                        else if (f7_alt)
                            op = rv_decode_pkg::dec_sub;
                    end
                    3'd1: op = f7_zero ? rv_decode_pkg::dec_sll : rv_decode_pkg::op_illegal;
                    3'd2: op = f7_zero ? rv_decode_pkg::dec_slt : rv_decode_pkg::op_illegal;
                    3'd3: op = f7_zero ? rv_decode_pkg::dec_sltu : rv_decode_pkg::op_illegal;
                    3'd4: op = f7_zero ? rv_decode_pkg::dec_xor : rv_decode_pkg::op_illegal;
                    3'd5: begin
                        if (f7_zero)
                            op = rv_decode_pkg::dec_srl;
                        else if (f7_alt)
                            op = rv_decode_pkg::dec_sra;
                    end
                    3'd6: op = f7_zero ? rv_decode_pkg::dec_or : rv_decode_pkg::op_illegal;
                    3'd7: op = f7_zero ? rv_decode_pkg::dec_and : rv_decode_pkg::op_illegal;
                endcase
            end
            default: op = rv_decode_pkg::op_illegal;
        endcase
    end

    assign legal = (op != rv_decode_pkg::op_illegal);

    // Indices per format, all zero on an illegal encoding
    assign cls.op    = op;
    assign cls.rs1   = (use_rs1 && legal) ? instr[19:15] : '0;
    assign cls.rs2   = (use_rs2 && legal) ? instr[24:20] : '0;
    assign cls.rd    = (use_rd && legal) ? instr[11:7] : '0;
    assign cls.imm   = '0;
    assign cls.shamt = '0;

endmodule

// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN    = 32;
    localparam int REG_W   = 5;
    localparam int SHAMT_W = 5;
    localparam int INSTR_W = 32;

    // Major opcodes, RV32I encodings
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // Decoded operation handed to execute
    typedef enum logic [5:0] {
        op_none    = 6'd0,
        dec_addi   = 6'd1,
        dec_slli   = 6'd2,
        dec_slti   = 6'd3,
        dec_sltiu  = 6'd4,
        dec_xori   = 6'd5,
        dec_srli   = 6'd6,
        dec_srai   = 6'd7,
        dec_ori    = 6'd8,
        dec_andi   = 6'd9,
        dec_add    = 6'd10,
        dec_sub    = 6'd11,
        dec_sll    = 6'd12,
        dec_slt    = 6'd13,
        dec_sltu   = 6'd14,
        dec_xor    = 6'd15,
        dec_srl    = 6'd16,
        dec_sra    = 6'd17,
        dec_or     = 6'd18,
        dec_and    = 6'd19,
        dec_jal    = 6'd20,
        dec_jalr   = 6'd21,
        dec_beq    = 6'd22,
        dec_bne    = 6'd23,
        dec_blt    = 6'd24,
        dec_bge    = 6'd25,
        dec_bltu   = 6'd26,
        dec_bgeu   = 6'd27,
        dec_lui    = 6'd28,
        dec_auipc  = 6'd29,
        dec_lb     = 6'd30,
        dec_lh     = 6'd31,
        dec_lw     = 6'd32,
        dec_lbu    = 6'd33,
        dec_lhu    = 6'd34,
        dec_sb     = 6'd35,
        dec_sh     = 6'd36,
        dec_sw     = 6'd37,
        op_illegal = 6'd38
    } dec_op_e;

    ////////////////////
    // Decode result
    ////////////////////
    typedef struct packed {
        dec_op_e            op;
        logic [REG_W-1:0]   rs1;
        logic [REG_W-1:0]   rs2;
        logic [REG_W-1:0]   rd;
        logic [XLEN-1:0]    imm;
        logic [SHAMT_W-1:0] shamt;
    } dec_result_t;

endpackage
